// ==== rtl/noc_tile_pkg.sv ====
// Types shared by every block of one mesh tile
// Coordinates are 2 bits wide, so the mesh is at most 4x4
// Every packet is one 34-bit flit; bursts and multicast are not supported
package noc_tile_pkg;

  localparam int unsigned COORD_W    = 2;
  localparam int unsigned ADDR_W     = 8;
  localparam int unsigned DATA_W     = 16;
  localparam int unsigned NUM_PORTS  = 5;
  localparam int unsigned FIFO_DEPTH = 4;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;

  // Requests travel to the owner of the scratchpad, replies travel back
  typedef enum logic [1:0] {
    KIND_RD_REQ = 2'd0,
    KIND_WR_REQ = 2'd1,
    KIND_RD_RSP = 2'd2,
    KIND_WR_ACK = 2'd3
  } kind_e;

  // East increases x, north increases y
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_S = 3'd2,
    PORT_W = 3'd3,
    PORT_L = 3'd4
  } port_e;

  ////////////////////////////////////////
  // Flit layout, MSB first
  ////////////////////////////////////////

  typedef struct packed {
    coord_t dst_x;
    coord_t dst_y;
    coord_t src_x;
    coord_t src_y;
    kind_e  kind;
    addr_t  addr;
    data_t  data;
  } flit_t;

endpackage

// ==== rtl/flit_fifo.sv ====
// Synchronous FIFO with FIFO_DEPTH entries and no back-pressure
// A push while full is silently dropped; the sender must pace itself
// A pop while empty is ignored
`timescale 1ns/1ps

module flit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     empty_o,
  output payload_t head_o
);
  import noc_tile_pkg::*;

  payload_t                          mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(FIFO_DEPTH + 1)-1:0] count_q;
  logic                              do_push;
  logic                              do_pop;

  assign empty_o = (count_q == '0);
  assign do_push = push_i && (32'(count_q) != FIFO_DEPTH);
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (32'(wr_ptr_q) == FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (32'(rd_ptr_q) == FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== rtl/route_compute.sv ====
// Combinational XY route decision for the head flit of one input
// X is resolved first, then Y; a flit for this tile goes Local
`timescale 1ns/1ps

module route_compute (
  input  noc_tile_pkg::coord_t               my_x_i,
  input  noc_tile_pkg::coord_t               my_y_i,
  input  logic                               valid_i,
  input  noc_tile_pkg::flit_t                flit_i,
  output logic [noc_tile_pkg::NUM_PORTS-1:0] req_o
);
  import noc_tile_pkg::*;

  port_e dir;

  always_comb begin
    if (flit_i.dst_x > my_x_i) begin
      dir = PORT_E;
    end else if (flit_i.dst_x < my_x_i) begin
      dir = PORT_W;
    end else if (flit_i.dst_y > my_y_i) begin
      dir = PORT_N;
    end else if (flit_i.dst_y < my_y_i) begin
      dir = PORT_S;
    end else begin
      dir = PORT_L;
    end
  end

  // One-hot request, silent while the FIFO is empty
  always_comb begin
    req_o = '0;
    if (valid_i) begin
      req_o[dir] = 1'b1;
    end
  end

endmodule

// ==== rtl/switch_alloc.sv ====
// Per-output round-robin allocation and registered crossbar
// Each input requests at most one output per cycle, so it gets at most one grant
// Grants are combinational and pop the input FIFOs in the same cycle
`timescale 1ns/1ps

module switch_alloc (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [noc_tile_pkg::NUM_PORTS-1:0][noc_tile_pkg::NUM_PORTS-1:0] req_i,
  input  noc_tile_pkg::flit_t [noc_tile_pkg::NUM_PORTS-1:0] flit_i,
  output logic [noc_tile_pkg::NUM_PORTS-1:0]    grant_o,
  output logic [noc_tile_pkg::NUM_PORTS-1:0]    out_valid_o,
  output noc_tile_pkg::flit_t [noc_tile_pkg::NUM_PORTS-1:0] out_flit_o
);
  import noc_tile_pkg::*;

  // Input that has first claim on each output
  port_e                ptr_q    [NUM_PORTS];
  port_e                ptr_next [NUM_PORTS];
  port_e                win_idx  [NUM_PORTS];
  logic [NUM_PORTS-1:0] win_valid;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Scan from the pointer downwards so the nearest requester wins
  always_comb begin
    int unsigned cand;
    for (int o = 0; o < NUM_PORTS; o++) begin
      win_valid[o] = 1'b0;
      win_idx[o]   = PORT_N;
      for (int k = NUM_PORTS - 1; k >= 0; k--) begin
        cand = 32'(ptr_q[o]) + k;
        if (cand >= NUM_PORTS) begin
          cand = cand - NUM_PORTS;
        end
        if (req_i[cand][o]) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = port_e'(cand);
        end
      end
      ptr_next[o] = (win_idx[o] == PORT_L) ? PORT_N : port_e'(win_idx[o] + 3'd1);
    end
  end

  always_comb begin
    grant_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (win_valid[o]) begin
        grant_o[win_idx[o]] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Crossbar register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        ptr_q[o] <= PORT_N;
      end
    end else begin
      out_valid_o <= win_valid;
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (win_valid[o]) begin
          ptr_q[o] <= ptr_next[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (win_valid[o]) begin
        out_flit_o[o] <= flit_i[win_idx[o]];
      end
    end
  end

endmodule

// ==== rtl/noc_router.sv ====
// Five-port single-flit router with XY routing
// Inputs have no back-pressure; each is buffered by a 4-deep FIFO
// A flit arriving at a full input FIFO is dropped
// Uncontested latency is two cycles from input valid to output valid
`timescale 1ns/1ps

module noc_router (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  noc_tile_pkg::coord_t                             my_x_i,
  input  noc_tile_pkg::coord_t                             my_y_i,
  input  logic [noc_tile_pkg::NUM_PORTS-1:0]               in_valid_i,
  input  noc_tile_pkg::flit_t [noc_tile_pkg::NUM_PORTS-1:0] in_flit_i,
  output logic [noc_tile_pkg::NUM_PORTS-1:0]               out_valid_o,
  output noc_tile_pkg::flit_t [noc_tile_pkg::NUM_PORTS-1:0] out_flit_o
);
  import noc_tile_pkg::*;

  logic  [NUM_PORTS-1:0]                fifo_empty;
  logic  [NUM_PORTS-1:0]                fifo_pop;
  flit_t [NUM_PORTS-1:0]                fifo_head;
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] route_req;

  // Input buffer and route stage per port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    flit_fifo #(
      .payload_t(flit_t)
    ) i_in_fifo (
      .clk_i,
      .arst_n_i,
      .push_i  (in_valid_i[p]),
      .data_i  (in_flit_i[p]),
      .pop_i   (fifo_pop[p]),
      .empty_o (fifo_empty[p]),
      .head_o  (fifo_head[p])
    );

    route_compute i_route (
      .my_x_i,
      .my_y_i,
      .valid_i (!fifo_empty[p]),
      .flit_i  (fifo_head[p]),
      .req_o   (route_req[p])
    );
  end

  switch_alloc i_alloc (
    .clk_i,
    .arst_n_i,
    .req_i       (route_req),
    .flit_i      (fifo_head),
    .grant_o     (fifo_pop),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o)
  );

endmodule

// ==== rtl/scratch_mem.sv ====
// 256-word scratchpad, one access per cycle
// Contents are undefined after power-up; reset clears only the read register
// Read data is held until the next read strobe
`timescale 1ns/1ps

module scratch_mem (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                we_i,
  input  logic                re_i,
  input  noc_tile_pkg::addr_t addr_i,
  input  noc_tile_pkg::data_t wdata_i,
  output noc_tile_pkg::data_t rdata_o
);
  import noc_tile_pkg::*;

  data_t mem_q [2**ADDR_W];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Registered read path
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// ==== rtl/net_interface.sv ====
// Network interface between the local router port, the core and the scratchpad
// Replies to remote requests take priority over queued core requests
// Core requests queue in a 4-deep FIFO; a request arriving when it is full is lost
// Replies are built two cycles after the request leaves the router
`timescale 1ns/1ps

module net_interface (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  noc_tile_pkg::coord_t my_x_i,
  input  noc_tile_pkg::coord_t my_y_i,
  // Core request
  input  logic                 core_req_valid_i,
  input  logic                 core_req_write_i,
  input  noc_tile_pkg::coord_t core_req_dst_x_i,
  input  noc_tile_pkg::coord_t core_req_dst_y_i,
  input  noc_tile_pkg::addr_t  core_req_addr_i,
  input  noc_tile_pkg::data_t  core_req_wdata_i,
  // Core response
  output logic                 core_rsp_valid_o,
  output logic                 core_rsp_write_o,
  output noc_tile_pkg::coord_t core_rsp_src_x_o,
  output noc_tile_pkg::coord_t core_rsp_src_y_o,
  output noc_tile_pkg::data_t  core_rsp_rdata_o,
  // Router local port
  input  logic                 loc_in_valid_i,
  input  noc_tile_pkg::flit_t  loc_in_flit_i,
  output logic                 loc_out_valid_o,
  output noc_tile_pkg::flit_t  loc_out_flit_o,
  // Scratchpad
  output logic                 mem_we_o,
  output logic                 mem_re_o,
  output noc_tile_pkg::addr_t  mem_addr_o,
  output noc_tile_pkg::data_t  mem_wdata_o,
  input  noc_tile_pkg::data_t  mem_rdata_i
);
  import noc_tile_pkg::*;

  flit_t core_flit;
  flit_t q_head;
  logic  q_empty;
  logic  q_pop;
  logic  in_is_req;
  logic  req_valid_q;
  flit_t req_flit_q;
  logic  rsp_valid_q;
  flit_t rsp_flit_q;
  flit_t rsp_flit;

  ////////////////////////////////////////
  // Core to network
  ////////////////////////////////////////

  always_comb begin
    core_flit.dst_x = core_req_dst_x_i;
    core_flit.dst_y = core_req_dst_y_i;
    core_flit.src_x = my_x_i;
    core_flit.src_y = my_y_i;
    core_flit.kind  = core_req_write_i ? KIND_WR_REQ : KIND_RD_REQ;
    core_flit.addr  = core_req_addr_i;
    core_flit.data  = core_req_wdata_i;
  end

  flit_fifo #(
    .payload_t(flit_t)
  ) i_core_q (
    .clk_i,
    .arst_n_i,
    .push_i  (core_req_valid_i),
    .data_i  (core_flit),
    .pop_i   (q_pop),
    .empty_o (q_empty),
    .head_o  (q_head)
  );

  // Reply wins the local input when both are ready
  assign q_pop           = !q_empty && !rsp_valid_q;
  assign loc_out_valid_o = rsp_valid_q || !q_empty;
  assign loc_out_flit_o  = rsp_valid_q ? rsp_flit : q_head;

  ////////////////////////////////////////
  // Network to memory and core
  ////////////////////////////////////////

  assign in_is_req = (loc_in_flit_i.kind == KIND_RD_REQ) ||
                     (loc_in_flit_i.kind == KIND_WR_REQ);

  assign mem_we_o    = req_valid_q && (req_flit_q.kind == KIND_WR_REQ);
  assign mem_re_o    = req_valid_q && (req_flit_q.kind == KIND_RD_REQ);
  assign mem_addr_o  = req_flit_q.addr;
  assign mem_wdata_o = req_flit_q.data;

  // Read data arrives from the memory register in the reply cycle
  always_comb begin
    rsp_flit = rsp_flit_q;
    if (rsp_flit_q.kind == KIND_RD_RSP) begin
      rsp_flit.data = mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_valid_q      <= 1'b0;
      rsp_valid_q      <= 1'b0;
      core_rsp_valid_o <= 1'b0;
    end else begin
      req_valid_q      <= loc_in_valid_i && in_is_req;
      rsp_valid_q      <= req_valid_q;
      core_rsp_valid_o <= loc_in_valid_i && !in_is_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (loc_in_valid_i && in_is_req) begin
      req_flit_q <= loc_in_flit_i;
    end
    // Reply goes back to the requester
    if (req_valid_q) begin
      rsp_flit_q.dst_x <= req_flit_q.src_x;
      rsp_flit_q.dst_y <= req_flit_q.src_y;
      rsp_flit_q.src_x <= my_x_i;
      rsp_flit_q.src_y <= my_y_i;
      rsp_flit_q.kind  <= (req_flit_q.kind == KIND_WR_REQ) ? KIND_WR_ACK : KIND_RD_RSP;
      rsp_flit_q.addr  <= req_flit_q.addr;
      rsp_flit_q.data  <= req_flit_q.data;
    end
    if (loc_in_valid_i && !in_is_req) begin
      core_rsp_write_o <= (loc_in_flit_i.kind == KIND_WR_ACK);
      core_rsp_src_x_o <= loc_in_flit_i.src_x;
      core_rsp_src_y_o <= loc_in_flit_i.src_y;
      core_rsp_rdata_o <= loc_in_flit_i.data;
    end
  end

endmodule

// ==== rtl/noc_tile.sv ====
// One tile of a 2D mesh: router, network interface and scratchpad
// Links carry single-cycle valid strobes with no back-pressure
// Each router input holds at most 4 flits; further flits are dropped
// Tile coordinates come from my_x_i and my_y_i and must stay constant
`timescale 1ns/1ps

module noc_tile (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  noc_tile_pkg::coord_t my_x_i,
  input  noc_tile_pkg::coord_t my_y_i,
  // Incoming links
  input  logic                 n_valid_i,
  input  noc_tile_pkg::flit_t  n_flit_i,
  input  logic                 e_valid_i,
  input  noc_tile_pkg::flit_t  e_flit_i,
  input  logic                 s_valid_i,
  input  noc_tile_pkg::flit_t  s_flit_i,
  input  logic                 w_valid_i,
  input  noc_tile_pkg::flit_t  w_flit_i,
  // Outgoing links
  output logic                 n_valid_o,
  output noc_tile_pkg::flit_t  n_flit_o,
  output logic                 e_valid_o,
  output noc_tile_pkg::flit_t  e_flit_o,
  output logic                 s_valid_o,
  output noc_tile_pkg::flit_t  s_flit_o,
  output logic                 w_valid_o,
  output noc_tile_pkg::flit_t  w_flit_o,
  // Core request
  input  logic                 core_req_valid_i,
  input  logic                 core_req_write_i,
  input  noc_tile_pkg::coord_t core_req_dst_x_i,
  input  noc_tile_pkg::coord_t core_req_dst_y_i,
  input  noc_tile_pkg::addr_t  core_req_addr_i,
  input  noc_tile_pkg::data_t  core_req_wdata_i,
  // Core response
  output logic                 core_rsp_valid_o,
  output logic                 core_rsp_write_o,
  output noc_tile_pkg::coord_t core_rsp_src_x_o,
  output noc_tile_pkg::coord_t core_rsp_src_y_o,
  output noc_tile_pkg::data_t  core_rsp_rdata_o
);
  import noc_tile_pkg::*;

  logic  [NUM_PORTS-1:0] rt_in_valid;
  flit_t [NUM_PORTS-1:0] rt_in_flit;
  logic  [NUM_PORTS-1:0] rt_out_valid;
  flit_t [NUM_PORTS-1:0] rt_out_flit;
  logic                  mem_we;
  logic                  mem_re;
  addr_t                 mem_addr;
  data_t                 mem_wdata;
  data_t                 mem_rdata;

  ////////////////////////////////////////
  // Router
  ////////////////////////////////////////

  assign rt_in_valid[PORT_N] = n_valid_i;
  assign rt_in_flit[PORT_N]  = n_flit_i;
  assign rt_in_valid[PORT_E] = e_valid_i;
  assign rt_in_flit[PORT_E]  = e_flit_i;
  assign rt_in_valid[PORT_S] = s_valid_i;
  assign rt_in_flit[PORT_S]  = s_flit_i;
  assign rt_in_valid[PORT_W] = w_valid_i;
  assign rt_in_flit[PORT_W]  = w_flit_i;

  assign n_valid_o = rt_out_valid[PORT_N];
  assign n_flit_o  = rt_out_flit[PORT_N];
  assign e_valid_o = rt_out_valid[PORT_E];
  assign e_flit_o  = rt_out_flit[PORT_E];
  assign s_valid_o = rt_out_valid[PORT_S];
  assign s_flit_o  = rt_out_flit[PORT_S];
  assign w_valid_o = rt_out_valid[PORT_W];
  assign w_flit_o  = rt_out_flit[PORT_W];

  noc_router i_router (
    .clk_i,
    .arst_n_i,
    .my_x_i,
    .my_y_i,
    .in_valid_i  (rt_in_valid),
    .in_flit_i   (rt_in_flit),
    .out_valid_o (rt_out_valid),
    .out_flit_o  (rt_out_flit)
  );

  ////////////////////////////////////////
  // Interface and scratchpad
  ////////////////////////////////////////

  net_interface i_ni (
    .clk_i,
    .arst_n_i,
    .my_x_i,
    .my_y_i,
    .core_req_valid_i,
    .core_req_write_i,
    .core_req_dst_x_i,
    .core_req_dst_y_i,
    .core_req_addr_i,
    .core_req_wdata_i,
    .core_rsp_valid_o,
    .core_rsp_write_o,
    .core_rsp_src_x_o,
    .core_rsp_src_y_o,
    .core_rsp_rdata_o,
    .loc_in_valid_i  (rt_out_valid[PORT_L]),
    .loc_in_flit_i   (rt_out_flit[PORT_L]),
    .loc_out_valid_o (rt_in_valid[PORT_L]),
    .loc_out_flit_o  (rt_in_flit[PORT_L]),
    .mem_we_o        (mem_we),
    .mem_re_o        (mem_re),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata)
  );

  scratch_mem i_mem (
    .clk_i,
    .arst_n_i,
    .we_i    (mem_we),
    .re_i    (mem_re),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// ==== test/tb_noc_tile.sv ====
// Testbench for one mesh tile placed at (1,1)
// Stimulus and expected outputs come from test/noc_tile_stim.txt, run from the project root
// Flits on one output are matched by source, so order is only checked per input
// Stops at the first mismatch
`timescale 1ns/1ps

module tb_noc_tile;
  import noc_tile_pkg::*;

  typedef struct packed {
    logic   write;
    coord_t src_x;
    coord_t src_y;
    data_t  rdata;
  } rsp_t;

  logic       clk_i;
  logic       arst_n_i;
  logic       n_valid_i;
  flit_t      n_flit_i;
  logic       e_valid_i;
  flit_t      e_flit_i;
  logic       s_valid_i;
  flit_t      s_flit_i;
  logic       w_valid_i;
  flit_t      w_flit_i;
  logic       n_valid_o;
  flit_t      n_flit_o;
  logic       e_valid_o;
  flit_t      e_flit_o;
  logic       s_valid_o;
  flit_t      s_flit_o;
  logic       w_valid_o;
  flit_t      w_flit_o;
  logic       core_req_valid_i;
  logic       core_req_write_i;
  coord_t     core_req_dst_x_i;
  coord_t     core_req_dst_y_i;
  addr_t      core_req_addr_i;
  data_t      core_req_wdata_i;
  logic       core_rsp_valid_o;
  logic       core_rsp_write_o;
  coord_t     core_rsp_src_x_o;
  coord_t     core_rsp_src_y_o;
  data_t      core_rsp_rdata_o;

  // Expected results, one queue per link output plus the core response
  flit_t      exp_flit_q [4][$];
  rsp_t       exp_rsp_q [$];
  // Group being built from the stimulus file
  logic       pend_valid [4];
  flit_t      pend_flit [4];
  logic       pend_core;
  logic       pend_write;
  coord_t     pend_dst_x;
  coord_t     pend_dst_y;
  addr_t      pend_addr;
  data_t      pend_wdata;
  int         seed;
  logic [3:0] link_valid;
  flit_t      link_flit [4];

  noc_tile dut_i (
    .clk_i,
    .arst_n_i,
    .my_x_i (coord_t'(1)),
    .my_y_i (coord_t'(1)),
    .n_valid_i,
    .n_flit_i,
    .e_valid_i,
    .e_flit_i,
    .s_valid_i,
    .s_flit_i,
    .w_valid_i,
    .w_flit_i,
    .n_valid_o,
    .n_flit_o,
    .e_valid_o,
    .e_flit_o,
    .s_valid_o,
    .s_flit_o,
    .w_valid_o,
    .w_flit_o,
    .core_req_valid_i,
    .core_req_write_i,
    .core_req_dst_x_i,
    .core_req_dst_y_i,
    .core_req_addr_i,
    .core_req_wdata_i,
    .core_rsp_valid_o,
    .core_rsp_write_o,
    .core_rsp_src_x_o,
    .core_rsp_src_y_o,
    .core_rsp_rdata_o
  );

  // Index order follows port_e
  assign link_valid   = {w_valid_o, s_valid_o, e_valid_o, n_valid_o};
  assign link_flit[0] = n_flit_o;
  assign link_flit[1] = e_flit_o;
  assign link_flit[2] = s_flit_o;
  assign link_flit[3] = w_flit_o;

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic compare_field(input string sig, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      $display("ERR %0t %s exp %0h got %0h", $time, sig, want, got);
      abort_run();
    end
  endtask

  task automatic check_flit(input string sig, input flit_t want, input flit_t got);
    compare_field({sig, ".dst_x"}, 32'(want.dst_x), 32'(got.dst_x));
    compare_field({sig, ".dst_y"}, 32'(want.dst_y), 32'(got.dst_y));
    compare_field({sig, ".src_x"}, 32'(want.src_x), 32'(got.src_x));
    compare_field({sig, ".src_y"}, 32'(want.src_y), 32'(got.src_y));
    compare_field({sig, ".kind"}, 32'(want.kind), 32'(got.kind));
    compare_field({sig, ".addr"}, 32'(want.addr), 32'(got.addr));
    compare_field({sig, ".data"}, 32'(want.data), 32'(got.data));
  endtask

  task automatic check_rsp(input rsp_t want, input logic write, input coord_t src_x,
                           input coord_t src_y, input data_t rdata);
    compare_field("core_rsp_write_o", 32'(want.write), 32'(write));
    compare_field("core_rsp_src_x_o", 32'(want.src_x), 32'(src_x));
    compare_field("core_rsp_src_y_o", 32'(want.src_y), 32'(src_y));
    compare_field("core_rsp_rdata_o", 32'(want.rdata), 32'(rdata));
  endtask

  function automatic string link_name(input int p);
    case (p)
      0:       return "n_flit_o";
      1:       return "e_flit_o";
      2:       return "s_flit_o";
      default: return "w_flit_o";
    endcase
  endfunction

  // Oldest expected flit from the same source, or the oldest one if no source matches
  task automatic match_flit(input int p, input flit_t got);
    int idx;
    idx = -1;
    if (exp_flit_q[p].size() == 0) begin
      $display("Flit on %s at %0t with no expected entry", link_name(p), $time);
      abort_run();
    end else begin
      for (int i = 0; i < exp_flit_q[p].size(); i++) begin
        if (idx < 0 && exp_flit_q[p][i].src_x == got.src_x &&
            exp_flit_q[p][i].src_y == got.src_y) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        idx = 0;
      end
      check_flit(link_name(p), exp_flit_q[p][idx], got);
      exp_flit_q[p].delete(idx);
    end
  endtask

  task automatic match_rsp();
    rsp_t want;
    if (exp_rsp_q.size() == 0) begin
      $display("Core response at %0t with no expected entry", $time);
      abort_run();
    end else begin
      want = exp_rsp_q.pop_front();
      check_rsp(want, core_rsp_write_o, core_rsp_src_x_o, core_rsp_src_y_o, core_rsp_rdata_o);
    end
  endtask

  // Outputs are registered, so the rising edge sees last cycle's stable values
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      for (int p = 0; p < 4; p++) begin
        if (link_valid[p]) begin
          match_flit(p, link_flit[p]);
        end
      end
      if (core_rsp_valid_o) begin
        match_rsp();
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic flit_t make_flit(input logic [31:0] dx, input logic [31:0] dy,
                                      input logic [31:0] sx, input logic [31:0] sy,
                                      input logic [31:0] kind, input logic [31:0] addr,
                                      input logic [31:0] data);
    flit_t fl;
    fl.dst_x = coord_t'(dx);
    fl.dst_y = coord_t'(dy);
    fl.src_x = coord_t'(sx);
    fl.src_y = coord_t'(sy);
    fl.kind  = kind_e'(kind[1:0]);
    fl.addr  = addr_t'(addr);
    fl.data  = data_t'(data);
    return fl;
  endfunction

  function automatic logic queues_empty();
    logic empty;
    empty = (exp_rsp_q.size() == 0);
    for (int p = 0; p < 4; p++) begin
      if (exp_flit_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  // One cycle of strobes, then all valids low again
  task automatic apply_group();
    @(negedge clk_i);
    n_valid_i        = pend_valid[0];
    n_flit_i         = pend_flit[0];
    e_valid_i        = pend_valid[1];
    e_flit_i         = pend_flit[1];
    s_valid_i        = pend_valid[2];
    s_flit_i         = pend_flit[2];
    w_valid_i        = pend_valid[3];
    w_flit_i         = pend_flit[3];
    core_req_valid_i = pend_core;
    core_req_write_i = pend_write;
    core_req_dst_x_i = pend_dst_x;
    core_req_dst_y_i = pend_dst_y;
    core_req_addr_i  = pend_addr;
    core_req_wdata_i = pend_wdata;
    @(negedge clk_i);
    n_valid_i        = 1'b0;
    e_valid_i        = 1'b0;
    s_valid_i        = 1'b0;
    w_valid_i        = 1'b0;
    core_req_valid_i = 1'b0;
    pend_core        = 1'b0;
    for (int p = 0; p < 4; p++) begin
      pend_valid[p] = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!queues_empty() && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (!queues_empty()) begin
      $display("Timed out after 200 cycles waiting for expected outputs");
      abort_run();
    end
  endtask

  initial begin
    int          fd;
    int          idle;
    string       line;
    logic [7:0]  op;
    logic [31:0] f [8];
    rsp_t        rsp;
    seed             = 32'h34f5;
    arst_n_i         = 1'b0;
    n_valid_i        = 1'b0;
    n_flit_i         = '0;
    e_valid_i        = 1'b0;
    e_flit_i         = '0;
    s_valid_i        = 1'b0;
    s_flit_i         = '0;
    w_valid_i        = 1'b0;
    w_flit_i         = '0;
    core_req_valid_i = 1'b0;
    core_req_write_i = 1'b0;
    core_req_dst_x_i = '0;
    core_req_dst_y_i = '0;
    core_req_addr_i  = '0;
    core_req_wdata_i = '0;
    pend_core        = 1'b0;
    pend_write       = 1'b0;
    pend_dst_x       = '0;
    pend_dst_y       = '0;
    pend_addr        = '0;
    pend_wdata       = '0;
    for (int p = 0; p < 4; p++) begin
      pend_valid[p] = 1'b0;
      pend_flit[p]  = '0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    fd = $fopen("test/noc_tile_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file test/noc_tile_stim.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          for (int i = 0; i < 8; i++) begin
            f[i] = '0;
          end
          void'($sscanf(line, "%c %h %h %h %h %h %h %h %h", op,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]));
          case (op)
            "D": begin
              pend_valid[f[0][1:0]] = 1'b1;
              pend_flit[f[0][1:0]]  = make_flit(f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            end
            "E": begin
              exp_flit_q[f[0][1:0]].push_back(make_flit(f[1], f[2], f[3], f[4], f[5],
                                                        f[6], f[7]));
            end
            "C": begin
              pend_core  = 1'b1;
              pend_write = f[0][0];
              pend_dst_x = coord_t'(f[1]);
              pend_dst_y = coord_t'(f[2]);
              pend_addr  = addr_t'(f[3]);
              pend_wdata = data_t'(f[4]);
            end
            "R": begin
              rsp.write = f[0][0];
              rsp.src_x = coord_t'(f[1]);
              rsp.src_y = coord_t'(f[2]);
              rsp.rdata = data_t'(f[3]);
              exp_rsp_q.push_back(rsp);
            end
            "G": begin
              apply_group();
              wait_drain();
              idle = $random(seed) & 3;
              repeat (idle) @(negedge clk_i);
            end
            "I": begin
              repeat (f[0]) @(negedge clk_i);
            end
            default: begin
              $display("Unknown stimulus line: %s", line);
              abort_run();
            end
          endcase
        end
      end
      $fclose(fd);
      // Quiet tail catches stray flits
      repeat (20) @(negedge clk_i);
      if (queues_empty()) begin
        $display("NO ERRORS");
        $finish;
      end else begin
        $display("Expected outputs still pending when the stimulus ended");
        abort_run();
      end
    end
  end

endmodule

// ==== test/noc_tile_stim.txt ====
# Tile at (1,1); all numbers are hex
# D port dst_x dst_y src_x src_y kind addr data : drive a flit on an input link
# E port dst_x dst_y src_x src_y kind addr data : expect a flit on an output link
# C write dst_x dst_y addr wdata : core request    R write src_x src_y rdata : core response
# G : send the group and wait for its outputs      I n : n idle cycles
# Ports 0=N 1=E 2=S 3=W; kinds 0=RD_REQ 1=WR_REQ 2=RD_RSP 3=WR_ACK
# Idle after reset, 20 cycles
I 14
# Transit from every input
D 3 3 0 0 1 0 10 1234
D 2 1 3 1 0 1 22 abcd
D 0 1 0 1 3 0 33 5a5a
D 1 0 1 3 1 1 44 0f0f
E 1 3 0 0 1 0 10 1234
E 0 1 3 1 0 1 22 abcd
E 2 1 0 1 3 0 33 5a5a
E 3 0 1 3 1 1 44 0f0f
G
# Core read and write to tile (0,2)
C 0 0 2 55 0000
E 3 0 2 1 1 0 55 0000
G
C 1 0 2 56 beef
E 3 0 2 1 1 1 56 beef
G
# Remote write from (2,1) on East, then read back
D 1 1 1 2 1 1 80 c0de
E 1 2 1 1 1 3 80 c0de
G
D 1 1 1 2 1 0 80 0000
E 1 2 1 1 1 2 80 c0de
G
# Remote write from (0,1) on West, then read back
D 3 1 1 0 1 1 81 1111
E 3 0 1 1 1 3 81 1111
G
D 3 1 1 0 1 0 81 0000
E 3 0 1 1 1 2 81 1111
G
# Responses for the core
D 2 1 1 1 0 2 80 9876
R 0 1 0 9876
G
D 0 1 1 1 2 3 81 4321
R 1 1 2 4321
G
# North and South both heading east in the same cycle
D 0 3 1 1 2 0 90 aaaa
D 2 2 2 1 0 1 91 5555
E 1 3 1 1 2 0 90 aaaa
E 1 2 2 1 0 1 91 5555
G
I 14

// ==== files.f ====
rtl/noc_tile_pkg.sv
rtl/flit_fifo.sv
rtl/route_compute.sv
rtl/switch_alloc.sv
rtl/noc_router.sv
rtl/scratch_mem.sv
rtl/net_interface.sv
rtl/noc_tile.sv
test/tb_noc_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_noc_tile
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
